// File: rtl/fetch_pkg.sv
package fetch_pkg;

    // Address and data widths
    localparam int ADDR_BIT  = 32;
    localparam int INSTR_BIT = 32;
    localparam int BLOCK_BIT = 64;

    localparam int INSTR_BYTES      = INSTR_BIT / 8;
    localparam int BLOCK_BYTES      = 8;
    localparam int BLOCK_OFFSET_BIT = $clog2(BLOCK_BYTES);

    // Fetch queue sizing
    localparam int FETCH_QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_BIT     = $clog2(FETCH_QUEUE_DEPTH);
    localparam int QUEUE_CNT_BIT     = $clog2(FETCH_QUEUE_DEPTH + 1);

    // Enough for a full queue plus a dropped response, with one spare
    localparam int CREDIT_BIT = $clog2(FETCH_QUEUE_DEPTH + 3);

    localparam logic [ADDR_BIT-1:0] RESET_PC = 32'h0000_1000;

    // One returned block on its way to decode
    typedef struct packed {
        logic [BLOCK_BIT-1:0] data;
        logic [ADDR_BIT-1:0]  addr;
        logic                 start_upper;
    } fetch_entry_t;

endpackage

// File: rtl/pc_generator.sv
module pc_generator import fetch_pkg::*; (
    input  logic                  clk_i,
    input  logic                  arst_n_i,

    input  logic                  icache_req_ready_i,

    input  logic [ADDR_BIT-1:0]   trap_pc_i,
    input  logic                  trap_valid_i,
    input  logic [ADDR_BIT-1:0]   branch_pc_i,
    input  logic                  branch_valid_i,

    input  logic [CREDIT_BIT-1:0] credit_return_i,

    output logic [ADDR_BIT-1:0]   icache_req_addr_o,
    output logic                  icache_req_valid_o,
    output logic                  issue_o,
    output logic                  flush_o,
    output logic                  start_upper_o
);

    logic [ADDR_BIT-1:0]   req_addr_q;
    logic                  req_upper_q;
    logic [ADDR_BIT-1:0]   next_addr_q;
    logic                  next_upper_q;
    logic                  stale_q;
    logic [CREDIT_BIT-1:0] credit_q;
    logic                  req_en_q;

    logic                  redirect;
    logic [ADDR_BIT-1:0]   target_pc;
    logic [ADDR_BIT-1:0]   target_block;
    logic                  target_upper;
    logic                  accept;
    logic                  hold_old;

    // Trap beats branch
    assign redirect     = trap_valid_i | branch_valid_i;
    assign target_pc    = trap_valid_i ? trap_pc_i : branch_pc_i;
    assign target_block = {target_pc[ADDR_BIT-1:BLOCK_OFFSET_BIT], {BLOCK_OFFSET_BIT{1'b0}}};
    assign target_upper = target_pc[BLOCK_OFFSET_BIT-1];

    // Quiet until the first cycle out of reset
    assign icache_req_valid_o = req_en_q & (credit_q != '0);
    assign icache_req_addr_o  = req_addr_q;
    assign accept             = icache_req_valid_o & icache_req_ready_i;

    assign issue_o       = accept;
    assign start_upper_o = req_upper_q;

    // Request already on the bus keeps its old address
    assign hold_old = redirect & icache_req_valid_o & ~icache_req_ready_i;

    // Second flush when the held request finally goes out, so its answer is dropped
    assign flush_o = redirect | (stale_q & accept);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_addr_q  <= RESET_PC;
            req_upper_q <= RESET_PC[BLOCK_OFFSET_BIT-1];
            stale_q     <= 1'b0;
            credit_q    <= CREDIT_BIT'(FETCH_QUEUE_DEPTH);
            req_en_q    <= 1'b0;
        end else begin
            req_en_q <= 1'b1;
            credit_q <= credit_q - CREDIT_BIT'(accept) + credit_return_i;
            if (hold_old) begin
                stale_q <= 1'b1;
            end else if (redirect) begin
                req_addr_q  <= target_block;
                req_upper_q <= target_upper;
                stale_q     <= 1'b0;
            end else if (accept && stale_q) begin
                req_addr_q  <= next_addr_q;
                req_upper_q <= next_upper_q;
                stale_q     <= 1'b0;
            end else if (accept) begin
                req_addr_q  <= req_addr_q + ADDR_BIT'(BLOCK_BYTES);
                req_upper_q <= 1'b0;
            end
        end
    end

    // Parked redirect target
    always_ff @(posedge clk_i) begin
        if (hold_old) begin
            next_addr_q  <= target_block;
            next_upper_q <= target_upper;
        end
    end

    // Credits come back from the queue, never more than were handed out
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        credit_q <= CREDIT_BIT'(FETCH_QUEUE_DEPTH));

endmodule

// File: rtl/fetch_queue.sv
module fetch_queue import fetch_pkg::*; #(
    parameter type entry_t = fetch_entry_t
) (
    input  logic                  clk_i,
    input  logic                  arst_n_i,

    input  logic                  issue_i,
    input  logic [ADDR_BIT-1:0]   issue_addr_i,
    input  logic                  flush_i,
    input  logic                  start_upper_i,

    input  logic [BLOCK_BIT-1:0]  resp_data_i,
    input  logic                  resp_valid_i,

    input  logic                  pop_i,
    output entry_t                entry_o,
    output logic                  entry_valid_o,

    output logic [CREDIT_BIT-1:0] credit_return_o
);

    entry_t                   mem [FETCH_QUEUE_DEPTH];
    logic [QUEUE_PTR_BIT-1:0] wr_ptr_q;
    logic [QUEUE_PTR_BIT-1:0] rd_ptr_q;
    logic [QUEUE_CNT_BIT-1:0] count_q;

    // Address and start half of each request still in flight
    logic [ADDR_BIT-1:0]      side_addr [FETCH_QUEUE_DEPTH];
    logic                     side_upper [FETCH_QUEUE_DEPTH];
    logic [QUEUE_PTR_BIT-1:0] side_wr_q;
    logic [QUEUE_PTR_BIT-1:0] side_rd_q;
    logic [QUEUE_CNT_BIT-1:0] side_cnt_q;
    logic [QUEUE_CNT_BIT-1:0] stale_cnt_q;

    logic                     drop;
    logic                     push;
    logic                     pop_take;
    logic                     side_push;
    entry_t                   push_entry;

    assign entry_o       = mem[rd_ptr_q];
    assign entry_valid_o = (count_q != '0);

    // Stale answers are the oldest ones, responses come back in order
    assign drop      = resp_valid_i & (flush_i | (stale_cnt_q != '0));
    assign push      = resp_valid_i & ~drop;
    assign pop_take  = pop_i & entry_valid_o & ~flush_i;
    assign side_push = issue_i & ~flush_i;

    always_comb begin
        push_entry.data        = resp_data_i;
        push_entry.addr        = side_addr[side_rd_q];
        push_entry.start_upper = side_upper[side_rd_q];
    end

    // Discarded entries count as freed on a flush
    always_comb begin
        if (flush_i) begin
            credit_return_o = CREDIT_BIT'(count_q) + CREDIT_BIT'(drop);
        end else begin
            credit_return_o = CREDIT_BIT'(pop_take) + CREDIT_BIT'(drop);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            side_wr_q   <= '0;
            side_rd_q   <= '0;
            side_cnt_q  <= '0;
            stale_cnt_q <= '0;
        end else if (flush_i) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            side_wr_q   <= '0;
            side_rd_q   <= '0;
            side_cnt_q  <= '0;
            // Everything still out there, including a request issued now
            stale_cnt_q <= stale_cnt_q + side_cnt_q + QUEUE_CNT_BIT'(issue_i)
                           - QUEUE_CNT_BIT'(resp_valid_i);
        end else begin
            if (push) begin
                wr_ptr_q  <= wr_ptr_q + QUEUE_PTR_BIT'(1);
                side_rd_q <= side_rd_q + QUEUE_PTR_BIT'(1);
            end
            if (pop_take) begin
                rd_ptr_q <= rd_ptr_q + QUEUE_PTR_BIT'(1);
            end
            if (side_push) begin
                side_wr_q <= side_wr_q + QUEUE_PTR_BIT'(1);
            end
            if (drop) begin
                stale_cnt_q <= stale_cnt_q - QUEUE_CNT_BIT'(1);
            end
            count_q    <= count_q + QUEUE_CNT_BIT'(push) - QUEUE_CNT_BIT'(pop_take);
            side_cnt_q <= side_cnt_q + QUEUE_CNT_BIT'(side_push) - QUEUE_CNT_BIT'(push);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= push_entry;
        end
        if (side_push) begin
            side_addr[side_wr_q]  <= issue_addr_i;
            side_upper[side_wr_q] <= start_upper_i;
        end
    end

    // Credit scheme upstream keeps room for every response
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        push |-> count_q != QUEUE_CNT_BIT'(FETCH_QUEUE_DEPTH));

endmodule

// File: rtl/decode_feeder.sv
module decode_feeder import fetch_pkg::*; (
    input  logic                 clk_i,
    input  logic                 arst_n_i,

    input  logic                 flush_i,

    input  fetch_entry_t         entry_i,
    input  logic                 entry_valid_i,
    output logic                 pop_o,

    output logic [INSTR_BIT-1:0] dec_instr_o,
    output logic [ADDR_BIT-1:0]  dec_pc_o,
    output logic                 dec_valid_o,
    input  logic                 dec_ready_i
);

    fetch_entry_t block_q;
    logic         held_q;
    logic         upper_q;
    logic         used_up;

    // Block is done once its upper instruction is taken
    assign used_up = ~held_q | (dec_ready_i & upper_q);
    assign pop_o   = entry_valid_i & used_up & ~flush_i;

    assign dec_valid_o = held_q;
    assign dec_instr_o = upper_q ? block_q.data[BLOCK_BIT-1 -: INSTR_BIT]
                                 : block_q.data[INSTR_BIT-1:0];
    assign dec_pc_o    = upper_q ? block_q.addr + ADDR_BIT'(INSTR_BYTES)
                                 : block_q.addr;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            held_q  <= 1'b0;
            upper_q <= 1'b0;
        end else if (flush_i) begin
            held_q <= 1'b0;
        end else if (pop_o) begin
            held_q  <= 1'b1;
            upper_q <= entry_i.start_upper;
        end else if (held_q && dec_ready_i) begin
            if (upper_q) begin
                held_q <= 1'b0;
            end else begin
                upper_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            block_q <= entry_i;
        end
    end

    // Decode sees a steady instruction while it stalls
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        dec_valid_o && !dec_ready_i && !flush_i
        |=> dec_valid_o && $stable(dec_instr_o) && $stable(dec_pc_o));

endmodule

// File: rtl/fetch_unit.sv
module fetch_unit import fetch_pkg::*; (
    input  logic                 clk_i,
    input  logic                 arst_n_i,

    // Instruction cache request
    output logic [ADDR_BIT-1:0]  icache_req_addr_o,
    output logic                 icache_req_valid_o,
    input  logic                 icache_req_ready_i,

    // Instruction cache response
    input  logic [BLOCK_BIT-1:0] icache_resp_data_i,
    input  logic                 icache_resp_valid_i,

    // Redirects
    input  logic [ADDR_BIT-1:0]  trap_pc_i,
    input  logic                 trap_valid_i,
    input  logic [ADDR_BIT-1:0]  branch_pc_i,
    input  logic                 branch_valid_i,

    // Decode
    output logic [INSTR_BIT-1:0] dec_instr_o,
    output logic [ADDR_BIT-1:0]  dec_pc_o,
    output logic                 dec_valid_o,
    input  logic                 dec_ready_i
);

    logic                  issue;
    logic                  flush;
    logic                  start_upper;
    logic [CREDIT_BIT-1:0] credit_return;
    fetch_entry_t          entry;
    logic                  entry_valid;
    logic                  pop;

    pc_generator i_pc_generator (
        .clk_i              (clk_i),
        .arst_n_i           (arst_n_i),
        .icache_req_ready_i (icache_req_ready_i),
        .trap_pc_i          (trap_pc_i),
        .trap_valid_i       (trap_valid_i),
        .branch_pc_i        (branch_pc_i),
        .branch_valid_i     (branch_valid_i),
        .credit_return_i    (credit_return),
        .icache_req_addr_o  (icache_req_addr_o),
        .icache_req_valid_o (icache_req_valid_o),
        .issue_o            (issue),
        .flush_o            (flush),
        .start_upper_o      (start_upper)
    );

    fetch_queue #(
        .entry_t (fetch_entry_t)
    ) i_fetch_queue (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .issue_i         (issue),
        .issue_addr_i    (icache_req_addr_o),
        .flush_i         (flush),
        .start_upper_i   (start_upper),
        .resp_data_i     (icache_resp_data_i),
        .resp_valid_i    (icache_resp_valid_i),
        .pop_i           (pop),
        .entry_o         (entry),
        .entry_valid_o   (entry_valid),
        .credit_return_o (credit_return)
    );

    decode_feeder i_decode_feeder (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .flush_i       (flush),
        .entry_i       (entry),
        .entry_valid_i (entry_valid),
        .pop_o         (pop),
        .dec_instr_o   (dec_instr_o),
        .dec_pc_o      (dec_pc_o),
        .dec_valid_o   (dec_valid_o),
        .dec_ready_i   (dec_ready_i)
    );

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk_o,
    output logic arst_n_o
);

    localparam int HALF_PERIOD = 4;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Low for 16 cycles, released on a falling edge
    initial begin
        arst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

// File: testbench/icache_model.sv
module icache_model import fetch_pkg::*; (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic [ADDR_BIT-1:0]  req_addr_i,
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    output logic [BLOCK_BIT-1:0] resp_data_o,
    output logic                 resp_valid_o
);

    localparam logic [31:0] INSTR_KEY = 32'hA5A5_0000;

    logic [31:0]         rand_state;
    logic [ADDR_BIT-1:0] addr_q [$];
    int                  due_q [$];
    int                  cycle;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Lower half holds A, upper half holds A + 4
    function automatic logic [BLOCK_BIT-1:0] block_at(input logic [ADDR_BIT-1:0] addr);
        return {(addr + 32'd4) ^ INSTR_KEY, addr ^ INSTR_KEY};
    endfunction

    initial begin
        rand_state   = 32'd4193;
        cycle        = 0;
        req_ready_o  = 1'b0;
        resp_valid_o = 1'b0;
        resp_data_o  = '0;
    end

    // Accepted requests wait 1 to 6 cycles
    always @(posedge clk_i) begin
        if (!arst_n_i) begin
            addr_q.delete();
            due_q.delete();
            cycle = 0;
        end else begin
            cycle = cycle + 1;
            if (req_valid_i && req_ready_o) begin
                rand_state = xorshift32(rand_state);
                addr_q.push_back(req_addr_i);
                due_q.push_back(cycle + 1 + int'(rand_state % 6));
            end
        end
    end

    // In order, at most one response per cycle
    always @(negedge clk_i) begin
        rand_state   = xorshift32(rand_state);
        req_ready_o  = (rand_state[1:0] != 2'b00);
        resp_valid_o = 1'b0;
        if (due_q.size() > 0 && due_q[0] <= cycle) begin
            resp_valid_o = 1'b1;
            resp_data_o  = block_at(addr_q.pop_front());
            void'(due_q.pop_front());
        end
    end

endmodule

// File: testbench/tb_fetch_unit.sv
module tb_fetch_unit import fetch_pkg::*; ();

    localparam int          TIMEOUT   = 500;
    localparam logic [31:0] INSTR_KEY = 32'hA5A5_0000;

    logic                 clk;
    logic                 arst_n;
    logic [ADDR_BIT-1:0]  icache_req_addr;
    logic                 icache_req_valid;
    logic                 icache_req_ready;
    logic [BLOCK_BIT-1:0] icache_resp_data;
    logic                 icache_resp_valid;
    logic [ADDR_BIT-1:0]  trap_pc;
    logic                 trap_valid;
    logic [ADDR_BIT-1:0]  branch_pc;
    logic                 branch_valid;
    logic [INSTR_BIT-1:0] dec_instr;
    logic [ADDR_BIT-1:0]  dec_pc;
    logic                 dec_valid;
    logic                 dec_ready;

    logic [ADDR_BIT-1:0]  got_pc [$];
    logic [INSTR_BIT-1:0] got_instr [$];
    logic [ADDR_BIT-1:0]  next_pc;
    logic [ADDR_BIT-1:0]  count_base;
    logic [31:0]          rand_state;
    int                   req_count;
    int                   error_count;
    int                   timeout_count;

    tb_clock_gen i_tb_clock_gen (.clk_o(clk), .arst_n_o(arst_n));

    icache_model i_icache_model (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .req_addr_i   (icache_req_addr),
        .req_valid_i  (icache_req_valid),
        .req_ready_o  (icache_req_ready),
        .resp_data_o  (icache_resp_data),
        .resp_valid_o (icache_resp_valid)
    );

    fetch_unit i_fetch_unit (
        .clk_i               (clk),
        .arst_n_i            (arst_n),
        .icache_req_addr_o   (icache_req_addr),
        .icache_req_valid_o  (icache_req_valid),
        .icache_req_ready_i  (icache_req_ready),
        .icache_resp_data_i  (icache_resp_data),
        .icache_resp_valid_i (icache_resp_valid),
        .trap_pc_i           (trap_pc),
        .trap_valid_i        (trap_valid),
        .branch_pc_i         (branch_pc),
        .branch_valid_i      (branch_valid),
        .dec_instr_o         (dec_instr),
        .dec_pc_o            (dec_pc),
        .dec_valid_o         (dec_valid),
        .dec_ready_i         (dec_ready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Handshakes as seen at the rising edge
    always @(posedge clk) begin
        if (arst_n && dec_valid && dec_ready) begin
            got_pc.push_back(dec_pc);
            got_instr.push_back(dec_instr);
        end
        if (arst_n && icache_req_valid && icache_req_ready && icache_req_addr >= count_base) begin
            req_count = req_count + 1;
        end
    end

    // Waits for n accepted instructions, then checks all received so far
    task automatic check_stream(input string name, input int n);
        int waited;
        logic [ADDR_BIT-1:0] pc;
        logic [INSTR_BIT-1:0] instr;
        waited = 0;
        while (got_pc.size() < n && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (got_pc.size() < n) begin
            $display("%s: timed out with %0d of %0d instructions at decode", name,
                     got_pc.size(), n);
            timeout_count++;
        end
        while (got_pc.size() > 0) begin
            pc    = got_pc.pop_front();
            instr = got_instr.pop_front();
            if (pc !== next_pc) begin
                $display("Fail %s: pc expected %h, actual %h", name, next_pc, pc);
                error_count++;
            end else if (instr !== (next_pc ^ INSTR_KEY)) begin
                $display("Fail %s: instr expected %h, actual %h", name, next_pc ^ INSTR_KEY,
                         instr);
                error_count++;
            end
            // Resync so one fault gives one line
            next_pc = pc + 32'd4;
        end
    endtask

    task automatic send_redirect(input string name, input logic trap_en,
                                 input logic [ADDR_BIT-1:0] trap_target, input logic branch_en,
                                 input logic [ADDR_BIT-1:0] branch_target,
                                 input logic [ADDR_BIT-1:0] expect_pc);
        @(negedge clk);
        dec_ready = 1'b0;
        @(negedge clk);
        check_stream(name, 0);
        trap_valid   = trap_en;
        trap_pc      = trap_target;
        branch_valid = branch_en;
        branch_pc    = branch_target;
        @(negedge clk);
        trap_valid   = 1'b0;
        branch_valid = 1'b0;
        next_pc      = expect_pc;
    endtask

    task automatic reset_stream_test();
        int waited;
        waited = 0;
        while (!arst_n && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
            if (!arst_n && dec_valid !== 1'b0) begin
                $display("Fail reset: dec_valid expected 0, actual %b", dec_valid);
                error_count++;
            end
            if (!arst_n && icache_req_valid !== 1'b0) begin
                $display("Fail reset: icache_req_valid expected 0, actual %b",
                         icache_req_valid);
                error_count++;
            end
        end
        if (!arst_n) begin
            $display("reset: timed out waiting for reset release");
            timeout_count++;
        end
        dec_ready = 1'b1;
        check_stream("reset_stream", 12);
    endtask

    task automatic random_ready_test();
        int waited;
        logic stalled;
        logic [ADDR_BIT-1:0] held_pc;
        logic [INSTR_BIT-1:0] held_instr;
        waited  = 0;
        stalled = 1'b0;
        while (got_pc.size() < 24 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
            if (stalled && dec_valid !== 1'b1) begin
                $display("Fail random_ready: held valid expected 1, actual %b", dec_valid);
                error_count++;
            end else if (stalled && dec_pc !== held_pc) begin
                $display("Fail random_ready: held pc expected %h, actual %h", held_pc, dec_pc);
                error_count++;
            end else if (stalled && dec_instr !== held_instr) begin
                $display("Fail random_ready: held instr expected %h, actual %h", held_instr,
                         dec_instr);
                error_count++;
            end
            rand_state = xorshift32(rand_state);
            dec_ready  = rand_state[3];
            stalled    = dec_valid && !dec_ready;
            held_pc    = dec_pc;
            held_instr = dec_instr;
        end
        check_stream("random_ready", 24);
    endtask

    task automatic branch_test();
        send_redirect("branch", 1'b0, '0, 1'b1, 32'h0000_2004, 32'h0000_2004);
        dec_ready = 1'b1;
        check_stream("branch", 10);
    endtask

    task automatic trap_priority_test();
        send_redirect("trap_priority", 1'b1, 32'h0000_3000, 1'b1, 32'h0000_4004, 32'h0000_3000);
        dec_ready = 1'b1;
        check_stream("trap_priority", 10);
    endtask

    task automatic backpressure_test();
        int waited;
        count_base = 32'h0000_5000;
        req_count  = 0;
        send_redirect("backpressure", 1'b0, '0, 1'b1, 32'h0000_5000, 32'h0000_5000);
        waited = 0;
        while (req_count < FETCH_QUEUE_DEPTH + 1 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (req_count < FETCH_QUEUE_DEPTH + 1) begin
            $display("backpressure: timed out with %0d cache requests", req_count);
            timeout_count++;
        end
        // Quiet window, no further request may go out
        waited = 0;
        while (req_count == FETCH_QUEUE_DEPTH + 1 && waited < 60) begin
            @(negedge clk);
            waited++;
        end
        if (req_count != FETCH_QUEUE_DEPTH + 1) begin
            $display("Fail backpressure: requests expected %0d, actual %0d",
                     FETCH_QUEUE_DEPTH + 1, req_count);
            error_count++;
        end
        if (dec_pc !== 32'h0000_5000) begin
            $display("Fail backpressure: pc expected %h, actual %h", 32'h0000_5000, dec_pc);
            error_count++;
        end
        dec_ready = 1'b1;
        check_stream("backpressure", 16);
    endtask

    initial begin
        trap_pc       = '0;
        trap_valid    = 1'b0;
        branch_pc     = '0;
        branch_valid  = 1'b0;
        dec_ready     = 1'b0;
        next_pc       = RESET_PC;
        count_base    = '1;
        rand_state    = 32'd4193;
        req_count     = 0;
        error_count   = 0;
        timeout_count = 0;
        reset_stream_test();
        random_ready_test();
        branch_test();
        trap_priority_test();
        backpressure_test();
        $display("Errors: %0d wrong values, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: build.f
rtl/fetch_pkg.sv
rtl/pc_generator.sv
rtl/fetch_queue.sv
rtl/decode_feeder.sv
rtl/fetch_unit.sv
testbench/tb_clock_gen.sv
testbench/icache_model.sv
testbench/tb_fetch_unit.sv
